// ==== filelist.f ====
common/fixed_pkg.sv
common/render_pkg.sv
common/escape_if.sv
hw/mandel_iterator/mandel_iterator.sv
hw/color_map.sv
hw/pixel_scheduler.sv
hw/mandel_render_top.sv
testbench/render_asserts.sv
testbench/tb_mandel_render.sv

// ==== testbench/tb_mandel_render.sv ====
`timescale 1ns/1ps

module tb_mandel_render;

	localparam int frame_w = 8;
	localparam int frame_h = 6;
	localparam int num_pixels = frame_w * frame_h;
	// Longest pixel plus handshake slack
	localparam int pixel_timeout = render_pkg::max_iter + 100;
	localparam int done_timeout = 16;
	// 0.01 and 0.5 in 4.23
	localparam int step_min = 83887;
	localparam int step_max = 4194304;

	// RGB 3-3-2 palette
	localparam render_pkg::color_t black = 8'b000_000_00;
	localparam render_pkg::color_t dim_red = 8'b011_001_00;
	localparam render_pkg::color_t pale_red = 8'b101_010_01;
	localparam render_pkg::color_t dusk = 8'b011_001_01;
	localparam render_pkg::color_t deep_blue = 8'b001_001_01;
	localparam render_pkg::color_t violet = 8'b011_010_10;
	localparam render_pkg::color_t green_blue = 8'b010_100_10;

	logic clk;
	logic reset;
	fixed_pkg::fixed_t x_start;
	fixed_pkg::fixed_t y_start;
	fixed_pkg::fixed_t pixel_step;
	logic mem_we;
	render_pkg::addr_t mem_addr;
	render_pkg::color_t mem_data;
	logic done;

	logic [15:0] lfsr;
	int errors;
	int tests_run;
	int tests_failed;
	logic timed_out;

	mandel_render_top #(
		.frame_width(frame_w),
		.frame_height(frame_h)
	) UUT (
		.clk(clk),
		.reset(reset),
		.x_start(x_start),
		.y_start(y_start),
		.pixel_step(pixel_step),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.done(done)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Stimulus source
	//////////////////////////////////////////////////

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One step per bit taken
	task automatic draw_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic render_pkg::iter_t model_count(
		input fixed_pkg::fixed_t cr,
		input fixed_pkg::fixed_t ci
	);
		fixed_pkg::fixed_t zr;
		fixed_pkg::fixed_t zi;
		fixed_pkg::fixed_t sq_r;
		fixed_pkg::fixed_t sq_i;
		fixed_pkg::fixed_t prod_ri;
		fixed_pkg::fixed_t next_r;
		fixed_pkg::fixed_t next_i;
		fixed_pkg::fixed_t mag;
		int n;
		logic escaped;
		zr = '0;
		zi = '0;
		n = 0;
		escaped = 1'b0;
		while (!escaped) begin
			sq_r = fixed_pkg::fixed_mul(zr, zr);
			sq_i = fixed_pkg::fixed_mul(zi, zi);
			prod_ri = fixed_pkg::fixed_mul(zr, zi);
			next_r = sq_r - sq_i + cr;
			next_i = prod_ri + prod_ri + ci;
			mag = sq_r + sq_i;
			escaped = (mag > fixed_pkg::fixed_four)
				|| (next_r > fixed_pkg::fixed_two) || (next_r < -fixed_pkg::fixed_two)
				|| (next_i > fixed_pkg::fixed_two) || (next_i < -fixed_pkg::fixed_two)
				|| (n == render_pkg::max_iter - 1);
			zr = next_r;
			zi = next_i;
			n++;
		end
		return render_pkg::iter_t'(n);
	endfunction

	// Colour of band k, threshold max_iter >> k
	function automatic render_pkg::color_t band_color(input int k);
		case (k)
			0: return black;
			1, 2: return dim_red;
			3: return pale_red;
			4: return dusk;
			5: return deep_blue;
			6: return violet;
			default: return green_blue;
		endcase
	endfunction

	// Highest threshold reached wins
	function automatic render_pkg::color_t model_color(input render_pkg::iter_t count);
		render_pkg::color_t result;
		result = green_blue;
		for (int k = 8; k >= 0; k--)
			if (count >= (render_pkg::max_iter >> k))
				result = band_color(k);
		return result;
	endfunction

	//////////////////////////////////////////////////
	// Compare tasks and waits
	//////////////////////////////////////////////////

	task automatic check_color(
		input string name,
		input render_pkg::color_t expected,
		input render_pkg::color_t actual
	);
		if (actual !== expected) begin
			$display("mismatch %s: colour expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_addr(
		input string name,
		input render_pkg::addr_t expected,
		input render_pkg::addr_t actual
	);
		if (actual !== expected) begin
			$display("mismatch %s: address expected %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	// Next write strobe, sampled mid-cycle
	task automatic wait_write(input string name, output logic ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < pixel_timeout) begin
			@(negedge clk);
			ok = mem_we;
			cycles++;
		end
		if (!ok) begin
			$display("%s: timeout, no memory write came within %0d cycles", name, cycles);
			timed_out = 1'b1;
		end
	endtask

	// done after the last write, with no write in between
	task automatic wait_done(input string name, output logic ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < done_timeout) begin
			@(negedge clk);
			ok = done;
			cycles++;
			if (mem_we) begin
				$display("%s: extra write after the last pixel", name);
				errors++;
			end
		end
		if (!ok) begin
			$display("%s: timeout, done never rose", name);
			timed_out = 1'b1;
		end else if (cycles != 1) begin
			$display("%s: done rose %0d cycles after the last write", name, cycles);
			errors++;
		end
	endtask

	//////////////////////////////////////////////////
	// Frame sequences
	//////////////////////////////////////////////////

	// Region loaded while reset is held for 4 cycles
	task automatic start_frame(
		input fixed_pkg::fixed_t xs,
		input fixed_pkg::fixed_t ys,
		input fixed_pkg::fixed_t step
	);
		@(posedge clk);
		reset <= 1'b1;
		x_start <= xs;
		y_start <= ys;
		pixel_step <= step;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
	endtask

	task automatic check_frame(
		input string name,
		input fixed_pkg::fixed_t xs,
		input fixed_pkg::fixed_t ys,
		input fixed_pkg::fixed_t step,
		input logic use_fixed,
		input render_pkg::color_t fixed_color
	);
		fixed_pkg::fixed_t cx;
		fixed_pkg::fixed_t cy;
		render_pkg::color_t expected;
		logic ok;
		cx = xs;
		cy = ys;
		errors = 0;
		for (int n = 0; n < num_pixels; n++) begin
			wait_write(name, ok);
			if (!ok)
				return;
			if (done) begin
				$display("%s: done already high at write %0d", name, n);
				errors++;
			end
			check_addr(name, render_pkg::addr_t'(n), mem_addr);
			expected = use_fixed ? fixed_color : model_color(model_count(cx, cy));
			check_color(name, expected, mem_data);
			// Raster stepping
			if (n % frame_w == frame_w - 1) begin
				cx = xs;
				cy = cy - step;
			end else begin
				cx = cx + step;
			end
		end
		wait_done(name, ok);
		if (!ok)
			return;
		// Quiet window, frame must stay finished
		repeat (50) begin
			@(negedge clk);
			if (mem_we || !done) begin
				$display("%s: write or done drop after the frame ended", name);
				errors++;
			end
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == 0 && !timed_out) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: failed with %0d errors", name, errors);
			tests_failed++;
		end
	endtask

	// Random region within +-2.0, step 0.01 to 0.5
	task automatic draw_region(
		output fixed_pkg::fixed_t xs,
		output fixed_pkg::fixed_t ys,
		output fixed_pkg::fixed_t step
	);
		logic [31:0] r;
		draw_bits(25, r);
		xs = fixed_pkg::fixed_t'(r[24:0]) - fixed_pkg::fixed_two;
		draw_bits(25, r);
		ys = fixed_pkg::fixed_t'(r[24:0]) - fixed_pkg::fixed_two;
		draw_bits(22, r);
		step = fixed_pkg::fixed_t'(step_min + int'(r % (step_max - step_min + 1)));
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		fixed_pkg::fixed_t xs;
		fixed_pkg::fixed_t ys;
		fixed_pkg::fixed_t step;
		string name;
		logic ok;
		int asserts_failed;
		reset = 1'b1;
		x_start = '0;
		y_start = '0;
		pixel_step = '0;
		lfsr = 16'd30149;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		timed_out = 1'b0;

		// Order, colours and done over random regions
		for (int t = 0; t < 3 && !timed_out; t++) begin
			name = $sformatf("random_frame_%0d", t);
			draw_region(xs, ys, step);
			start_frame(xs, ys, step);
			check_frame(name, xs, ys, step, 1'b0, black);
			finish_test(name);
		end

		// x from 3.5 leaves on the first step
		if (!timed_out) begin
			start_frame(27'sh1C00000, 27'sh0400000, 27'sh0100000);
			check_frame("fast_escape", 27'sh1C00000, 27'sh0400000, 27'sh0100000,
				1'b1, model_color(render_pkg::iter_t'(1)));
			finish_test("fast_escape");
		end

		// Tiny region at the origin never escapes
		if (!timed_out) begin
			start_frame('0, '0, 27'sh0000100);
			check_frame("interior", '0, '0, 27'sh0000100, 1'b1,
				model_color(render_pkg::iter_t'(render_pkg::max_iter)));
			finish_test("interior");
		end

		// Reset part way through, then a full frame again
		if (!timed_out) begin
			draw_region(xs, ys, step);
			start_frame(xs, ys, step);
			for (int n = 0; n < 10 && !timed_out; n++)
				wait_write("restart_after_reset", ok);
			start_frame(xs, ys, step);
			check_frame("restart_after_reset", xs, ys, step, 1'b0, black);
			finish_test("restart_after_reset");
		end

		asserts_failed = UUT.u_scheduler.u_render_asserts.violations;
		$display("tests run %0d, failed %0d, assertion failures %0d",
			tests_run, tests_failed, asserts_failed);
		if (tests_failed == 0 && !timed_out && asserts_failed == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== testbench/render_asserts.sv ====
`timescale 1ns/1ps

module render_asserts (
	input logic clk,
	input logic reset,
	input logic req,
	input logic ack,
	input logic mem_we,
	input logic done
);

	// Failed assertions so far, read by the testbench
	int violations = 0;

	//////////////////////////////////////////////////
	// Four-phase handshake
	//////////////////////////////////////////////////

	// req held until the engine answers
	req_held: assert property (@(posedge clk) disable iff (reset) req && !ack |=> req)
		else begin
			violations++;
			$error("req dropped before ack");
		end

	// ack only rises on a pending request
	ack_on_req: assert property (@(posedge clk) disable iff (reset) $rose(ack) |-> req)
		else begin
			violations++;
			$error("ack rose while req was low");
		end

	//////////////////////////////////////////////////
	// Write port
	//////////////////////////////////////////////////

	// One-cycle strobe
	we_single: assert property (@(posedge clk) disable iff (reset) mem_we |=> !mem_we)
		else begin
			violations++;
			$error("mem_we held longer than one cycle");
		end

	// Reset clears strobe and done
	reset_clears: assert property (@(posedge clk) reset |=> !mem_we && !done)
		else begin
			violations++;
			$error("mem_we or done high after reset");
		end

endmodule

// Attached to every scheduler instance
bind pixel_scheduler render_asserts u_render_asserts (
	.clk(clk),
	.reset(reset),
	.req(req_q),
	.ack(job.ack),
	.mem_we(mem_we),
	.done(done)
);

// ==== hw/mandel_render_top.sv ====
`timescale 1ns/1ps

module mandel_render_top #(
	parameter int frame_width = render_pkg::default_width,
	parameter int frame_height = render_pkg::default_height
) (
	input logic clk,
	input logic reset,
	input fixed_pkg::fixed_t x_start,
	input fixed_pkg::fixed_t y_start,
	input fixed_pkg::fixed_t pixel_step,
	output logic mem_we,
	output render_pkg::addr_t mem_addr,
	output render_pkg::color_t mem_data,
	output logic done
);

	// One point in flight between sweep and engine
	escape_if job ();

	//////////////////////////////////////////////////
	// Raster sweep and frame buffer writes
	//////////////////////////////////////////////////

	pixel_scheduler #(
		.frame_width(frame_width),
		.frame_height(frame_height)
	) u_scheduler (
		.clk(clk),
		.reset(reset),
		.x_start(x_start),
		.y_start(y_start),
		.pixel_step(pixel_step),
		.job(job.requester),
		.mem_we(mem_we),
		.mem_addr(mem_addr),
		.mem_data(mem_data),
		.done(done)
	);

	// Escape-time engine
	mandel_iterator u_iterator (
		.clk(clk),
		.reset(reset),
		.job(job.engine)
	);

endmodule

// ==== hw/pixel_scheduler.sv ====
`timescale 1ns/1ps

module pixel_scheduler #(
	parameter int frame_width = render_pkg::default_width,
	parameter int frame_height = render_pkg::default_height
) (
	input logic clk,
	input logic reset,
	input fixed_pkg::fixed_t x_start,
	input fixed_pkg::fixed_t y_start,
	input fixed_pkg::fixed_t pixel_step,
	escape_if.requester job,
	output logic mem_we,
	output render_pkg::addr_t mem_addr,
	output render_pkg::color_t mem_data,
	output logic done
);

	localparam render_pkg::addr_t last_col = render_pkg::addr_t'(frame_width - 1);
	localparam render_pkg::addr_t last_row = render_pkg::addr_t'(frame_height - 1);

	typedef enum logic [1:0] {
		st_send,
		st_wait,
		st_finish
	} state_t;

	state_t state;
	logic req_q;

	// Raster position and pixel index
	render_pkg::addr_t col;
	render_pkg::addr_t row;
	render_pkg::addr_t pix_addr;

	// Coordinate of the pixel in flight
	fixed_pkg::fixed_t cur_x;
	fixed_pkg::fixed_t cur_y;

	render_pkg::color_t pix_color;
	logic last_pixel;

	color_map u_color_map (
		.count(job.count),
		.color(pix_color)
	);

	assign last_pixel = (col == last_col) && (row == last_row);

	//////////////////////////////////////////////////
	// Sweep and handshake
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_send;
			req_q <= 1'b0;
			mem_we <= 1'b0;
			done <= 1'b0;
			col <= '0;
			row <= '0;
			pix_addr <= '0;
			cur_x <= x_start;
			cur_y <= y_start;
		end else begin
			// Single-cycle write strobe
			mem_we <= 1'b0;
			case (state)
				st_send: begin
					// Previous job fully released
					if (!job.ack) begin
						req_q <= 1'b1;
						state <= st_wait;
					end
				end
				st_wait: begin
					if (job.ack) begin
						req_q <= 1'b0;
						mem_we <= 1'b1;
						mem_addr <= pix_addr;
						mem_data <= pix_color;
						pix_addr <= pix_addr + 1'b1;
						// Next coordinate in raster order
						if (col == last_col) begin
							col <= '0;
							row <= row + 1'b1;
							cur_x <= x_start;
							cur_y <= cur_y - pixel_step;
						end else begin
							col <= col + 1'b1;
							cur_x <= cur_x + pixel_step;
						end
						state <= last_pixel ? st_finish : st_send;
					end
				end
				st_finish: begin
					// Frame complete, hold until reset
					done <= 1'b1;
				end
				default: begin
					state <= st_send;
				end
			endcase
		end
	end

	assign job.req = req_q;
	assign job.c_r = cur_x;
	assign job.c_i = cur_y;

endmodule

// ==== hw/color_map.sv ====
`timescale 1ns/1ps

module color_map (
	input render_pkg::iter_t count,
	output render_pkg::color_t color
);

	// Palette, RGB 3-3-2
	localparam render_pkg::color_t black = 8'b000_000_00;
	localparam render_pkg::color_t dim_red = 8'b011_001_00;
	localparam render_pkg::color_t pale_red = 8'b101_010_01;
	localparam render_pkg::color_t dusk = 8'b011_001_01;
	localparam render_pkg::color_t deep_blue = 8'b001_001_01;
	localparam render_pkg::color_t violet = 8'b011_010_10;
	localparam render_pkg::color_t green_blue = 8'b010_100_10;

	localparam int lim = render_pkg::max_iter;

	// Thresholds halve each band, highest first
	always_comb begin
		if (count >= lim)
			color = black;
		else if (count >= (lim >> 1))
			color = dim_red;
		else if (count >= (lim >> 2))
			color = dim_red;
		else if (count >= (lim >> 3))
			color = pale_red;
		else if (count >= (lim >> 4))
			color = dusk;
		else if (count >= (lim >> 5))
			color = deep_blue;
		else if (count >= (lim >> 6))
			color = violet;
		// Bands 7, 8 and below share one colour
		else
			color = green_blue;
	end

endmodule

// ==== hw/mandel_iterator/mandel_iterator.sv ====
`timescale 1ns/1ps

module mandel_iterator (
	input logic clk,
	input logic reset,
	escape_if.engine job
);

	typedef enum logic [1:0] {
		st_idle,
		st_compute,
		st_respond
	} state_t;

	state_t state;
	logic ack_q;

	// Point and current z
	fixed_pkg::fixed_t cr;
	fixed_pkg::fixed_t ci;
	fixed_pkg::fixed_t zr;
	fixed_pkg::fixed_t zi;
	render_pkg::iter_t iter_count;

	// One step of z
	fixed_pkg::fixed_t zr_sq;
	fixed_pkg::fixed_t zi_sq;
	fixed_pkg::fixed_t zr_zi;
	fixed_pkg::fixed_t zr_next;
	fixed_pkg::fixed_t zi_next;
	fixed_pkg::fixed_t mag_sq;
	logic escape;

	//////////////////////////////////////////////////
	// Datapath
	//////////////////////////////////////////////////

	always_comb begin
		zr_sq = fixed_pkg::fixed_mul(zr, zr);
		zi_sq = fixed_pkg::fixed_mul(zi, zi);
		zr_zi = fixed_pkg::fixed_mul(zr, zi);
		// z*z + c
		zr_next = zr_sq - zi_sq + cr;
		zi_next = (zr_zi <<< 1) + ci;
		// Magnitude from the squares formed this step
		mag_sq = zr_sq + zi_sq;
	end

	// Any one of these ends the point
	assign escape = (mag_sq > fixed_pkg::fixed_four)
		|| (zr_next > fixed_pkg::fixed_two)
		|| (zr_next < -fixed_pkg::fixed_two)
		|| (zi_next > fixed_pkg::fixed_two)
		|| (zi_next < -fixed_pkg::fixed_two)
		|| (iter_count == render_pkg::iter_t'(render_pkg::max_iter - 1));

	// z, c and the count
	always_ff @(posedge clk) begin
		case (state)
			st_idle: begin
				// Load the point, start z at zero
				if (job.req) begin
					cr <= job.c_r;
					ci <= job.c_i;
					zr <= '0;
					zi <= '0;
					iter_count <= '0;
				end
			end
			st_compute: begin
				zr <= zr_next;
				zi <= zi_next;
				iter_count <= iter_count + 1'b1;
			end
			default: begin
				// Hold count for the scheduler
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_idle;
			ack_q <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (job.req)
						state <= st_compute;
				end
				st_compute: begin
					// ack goes high the cycle after the escaping step
					if (escape) begin
						state <= st_respond;
						ack_q <= 1'b1;
					end
				end
				st_respond: begin
					// Release once req is gone
					if (!job.req) begin
						state <= st_idle;
						ack_q <= 1'b0;
					end
				end
				default: begin
					state <= st_idle;
					ack_q <= 1'b0;
				end
			endcase
		end
	end

	assign job.ack = ack_q;
	assign job.count = iter_count;

endmodule

// ==== common/escape_if.sv ====
`timescale 1ns/1ps

// One escape-time job, four-phase req/ack
interface escape_if ();
	// Scheduler to iterator
	logic req;
	fixed_pkg::fixed_t c_r;
	fixed_pkg::fixed_t c_i;

	// Iterator to scheduler
	logic ack;
	render_pkg::iter_t count;

	// Scheduler side
	// c_r and c_i held stable while req is high
	modport requester (
		output req, c_r, c_i,
		input ack, count
	);

	// Iterator side
	// count held stable while ack is high
	modport engine (
		input req, c_r, c_i,
		output ack, count
	);
endinterface

// ==== common/render_pkg.sv ====
package render_pkg;

	//////////////////////////////////////////////////
	// Iteration count
	//////////////////////////////////////////////////

	// Iteration limit per point
	localparam int max_iter = 1000;

	// Count up to max_iter, one spare bit on top
	typedef logic [$clog2(max_iter):0] iter_t;

	//////////////////////////////////////////////////
	// Frame and pixel format
	//////////////////////////////////////////////////

	// Full VGA frame
	localparam int default_width = 640;
	localparam int default_height = 480;

	// Frame buffer address, enough for 640 x 480
	typedef logic [18:0] addr_t;

	// RGB 3-3-2
	// red [7:5], green [4:2], blue [1:0]
	typedef logic [7:0] color_t;

endpackage

// ==== common/fixed_pkg.sv ====
package fixed_pkg;

	//////////////////////////////////////////////////
	// 4.23 signed fixed point
	//////////////////////////////////////////////////

	// Sign, 3 integer bits, 23 fraction bits
	typedef logic signed [26:0] fixed_t;

	// 4.0, limit on the squared magnitude of z
	localparam fixed_t fixed_four = 27'sh2000000;

	// 2.0, limit on each component of z
	localparam fixed_t fixed_two = 27'sh1000000;

	// Truncating 4.23 product
	// Keeps the sign, drops the low 23 fraction bits
	// and the integer bits that cannot fit
	function automatic fixed_t fixed_mul(input fixed_t a, input fixed_t b);
		logic signed [53:0] prod;
		prod = a * b;
		// Sign first, then bits 48 down to 23
		return {prod[53], prod[48:23]};
	endfunction

endpackage
